// ==== design/otp_part_defines.svh ====
// Partition geometry, block counter width and OTP macro address width macros
`ifndef OTP_PART_DEFINES_SVH
`define OTP_PART_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Partition geometry
////////////////////////////////////////////////////////////////////////////

// One buffered block, as returned by a single 64-bit macro read
`define OTP_BLOCK_W 64

// Blocks held by the partition, the last one is the digest
`define OTP_PART_BLOCKS 4

// Byte offset of the first block inside the macro
`define OTP_PART_OFFSET 'h40

////////////////////////////////////////////////////////////////////////////
// Address widths
////////////////////////////////////////////////////////////////////////////

// Byte address space of the macro
`define OTP_BYTE_ADDR_W 11

// Macro is addressed in 16-bit halfwords
`define OTP_ADDR_SHIFT 1
`define OTP_ADDR_W 10

// Counter over the blocks of the partition
`define OTP_CNT_W 2

`endif

// ==== design/otp_macro_pkg.sv ====
// OTP macro port types: read command and macro response error code
`default_nettype none

package otp_macro_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Macro command
  ////////////////////////////////////////////////////////////////////////////

  // Raw read skips the macro ECC, normal read corrects single-bit errors
  typedef enum logic {
    ReadRaw = 1'b0,
    Read    = 1'b1
  } otp_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // Macro response error
  ////////////////////////////////////////////////////////////////////////////

  // Returned with every read-valid
  typedef enum logic [1:0] {
    MacroOk        = 2'd0,
    MacroError     = 2'd1,
    // Single-bit error, data was corrected by the macro
    MacroEccCorr   = 2'd2,
    // Data is not usable
    MacroEccUncorr = 2'd3
  } otp_macro_err_e;

endpackage : otp_macro_pkg

`default_nettype wire

// ==== design/otp_part_pkg.sv ====
// Partition types: FSM state, partition error code, read phase and response verdict
`default_nettype none

package otp_part_pkg;

  // Sequencing FSM, plain binary encoding
  typedef enum logic [2:0] {
    ResetSt         = 3'd0,
    InitSt          = 3'd1,
    InitWaitSt      = 3'd2,
    IdleSt          = 3'd3,
    CnstyReadSt     = 3'd4,
    CnstyReadWaitSt = 3'd5,
    ErrorSt         = 3'd6
  } part_state_e;

  // Partition error register, everything past MacroEccCorrError is terminal
  typedef enum logic [2:0] {
    NoError             = 3'd0,
    MacroError          = 3'd1,
    MacroEccCorrError   = 3'd2,
    MacroEccUncorrError = 3'd3,
    CheckFailError      = 3'd4,
    FsmStateError       = 3'd5
  } part_err_e;

  // Which read sequence the outstanding response belongs to
  typedef enum logic {
    PhaseInit  = 1'b0,
    PhaseCnsty = 1'b1
  } read_phase_e;

  // Classification of one macro response
  typedef enum logic [1:0] {
    VerdictOk   = 2'd0,
    VerdictCorr = 2'd1,
    VerdictFail = 2'd2
  } rsp_verdict_e;

endpackage : otp_part_pkg

`default_nettype wire

// ==== design/otp_part_fsm.sv ====
// Partition sequencing FSM with block counter, OTP address generation and lock state
`default_nettype none

`include "otp_part_defines.svh"

module otp_part_fsm
  import otp_part_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Partition control
  input  logic                   init_req_i,
  input  logic                   cnsty_chk_req_i,
  input  logic                   escalate_en_i,
  // OTP macro handshake
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  output logic                   otp_req_o,
  output logic [`OTP_ADDR_W-1:0] otp_addr_o,
  // Response classification
  output read_phase_e            rsp_phase_o,
  input  rsp_verdict_e           rsp_verdict_i,
  // Buffer control
  output logic                   buf_wr_en_o,
  output logic [`OTP_CNT_W-1:0]  blk_idx_o,
  output logic                   unlocked_o,
  // Status
  output logic                   init_done_o,
  output logic                   cnsty_chk_ack_o,
  output logic                   fsm_err_o
);

  localparam int unsigned CntW      = `OTP_CNT_W;
  localparam int unsigned ByteAddrW = `OTP_BYTE_ADDR_W;
  localparam int unsigned AddrW     = `OTP_ADDR_W;
  // Bytes per block as a shift amount
  localparam int unsigned BlkShift  = $clog2(`OTP_BLOCK_W / 8);

  localparam logic [CntW-1:0]      LastBlk    = CntW'(`OTP_PART_BLOCKS - 1);
  localparam logic [ByteAddrW-1:0] PartOffset = ByteAddrW'(`OTP_PART_OFFSET);

  part_state_e          state_d, state_q;
  logic [CntW-1:0]      cnt_q;
  logic                 cnt_en, cnt_clr;
  logic                 unlocked_d, unlocked_q;
  logic [ByteAddrW-1:0] byte_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Next state logic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    unlocked_d      = unlocked_q;
    otp_req_o       = 1'b0;
    rsp_phase_o     = PhaseInit;
    buf_wr_en_o     = 1'b0;
    cnt_en          = 1'b0;
    cnt_clr         = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one initialization request
      ResetSt: begin
        if (init_req_i) begin
          state_d = InitSt;
          cnt_clr = 1'b1;
        end
      end
      // Request held until the macro grants it
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      InitWaitSt: begin
        rsp_phase_o = PhaseInit;
        if (otp_rvalid_i) begin
          if (rsp_verdict_i != VerdictFail) begin
            buf_wr_en_o = 1'b1;
            // Digest is the last block, partition opens after it
            if (cnt_q == LastBlk) begin
              state_d    = IdleSt;
              unlocked_d = 1'b1;
            end else begin
              state_d = InitSt;
              cnt_en  = 1'b1;
            end
          end else begin
            state_d = ErrorSt;
          end
        end
      end
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          state_d = CnstyReadSt;
          cnt_clr = 1'b1;
        end
      end
      // Background re-read of every block
      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = CnstyReadWaitSt;
        end
      end
      CnstyReadWaitSt: begin
        rsp_phase_o = PhaseCnsty;
        if (otp_rvalid_i) begin
          if (rsp_verdict_i == VerdictFail) begin
            // Check is over, it found an error
            state_d         = ErrorSt;
            cnsty_chk_ack_o = 1'b1;
          end else if (cnt_q == LastBlk) begin
            state_d         = IdleSt;
            cnsty_chk_ack_o = 1'b1;
          end else begin
            state_d = CnstyReadSt;
            cnt_en  = 1'b1;
          end
        end
      end
      // Terminal, checks cannot run any more so requests are answered at once
      ErrorSt: begin
        cnsty_chk_ack_o = cnsty_chk_req_i;
      end
      // Unused encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
    // Lock down on the way into the error state
    if (state_d == ErrorSt) begin
      unlocked_d = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////////////////////////////////////////

  // Byte address of the current block, macro takes halfwords
  assign byte_addr  = PartOffset + (ByteAddrW'(cnt_q) << BlkShift);
  assign otp_addr_o = AddrW'(byte_addr >> `OTP_ADDR_SHIFT);

  assign blk_idx_o   = cnt_q;
  assign unlocked_o  = unlocked_q;
  assign init_done_o = unlocked_q;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= ResetSt;
      cnt_q      <= '0;
      unlocked_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      unlocked_q <= unlocked_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Request and address stay put until granted
  ReqHeldUntilGnt_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o && !otp_gnt_i && !escalate_en_i |=> otp_req_o && $stable(otp_addr_o));

  // Error state is terminal and never reports init done
  ErrorNoInitDone_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ErrorSt |=> state_q == ErrorSt && !$rose(init_done_o));

endmodule : otp_part_fsm

`default_nettype wire

// ==== design/otp_part_check.sv ====
// Response classification, buffer compare and partition error register
`default_nettype none

`include "otp_part_defines.svh"

module otp_part_check
  import otp_macro_pkg::*;
  import otp_part_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Macro response
  input  logic                    otp_rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0] otp_rdata_i,
  input  otp_macro_err_e          otp_err_i,
  // Sequencing context
  input  read_phase_e             rsp_phase_i,
  input  logic [`OTP_BLOCK_W-1:0] buf_rd_data_i,
  input  logic                    check_byp_en_i,
  input  logic                    escalate_en_i,
  output rsp_verdict_e            rsp_verdict_o,
  output part_err_e               error_o
);

  part_err_e rsp_code;
  part_err_e error_d, error_q;
  logic      mismatch;
  logic      terminal;

  // Compare only on re-reads, life cycle may bypass it
  assign mismatch = (rsp_phase_i == PhaseCnsty) && (otp_rdata_i != buf_rd_data_i) &&
                    !check_byp_en_i;

  always_comb begin : p_verdict
    unique case (otp_err_i)
      MacroOk: begin
        rsp_verdict_o = VerdictOk;
        rsp_code      = NoError;
      end
      MacroEccCorr: begin
        rsp_verdict_o = VerdictCorr;
        rsp_code      = MacroEccCorrError;
      end
      MacroEccUncorr: begin
        rsp_verdict_o = VerdictFail;
        rsp_code      = MacroEccUncorrError;
      end
      default: begin
        rsp_verdict_o = VerdictFail;
        rsp_code      = otp_part_pkg::MacroError;
      end
    endcase
    // Corrected data that still differs is a real mismatch
    if (mismatch && rsp_verdict_o != VerdictFail) begin
      rsp_verdict_o = VerdictFail;
      rsp_code      = CheckFailError;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error register
  ////////////////////////////////////////////////////////////////////////////

  // Corrected ECC is only a note, anything else sticks
  assign terminal = !(error_q inside {NoError, MacroEccCorrError});

  always_comb begin : p_err
    error_d = error_q;
    if (escalate_en_i) begin
      error_d = FsmStateError;
    end else if (otp_rvalid_i && !terminal && rsp_verdict_o != VerdictOk) begin
      error_d = rsp_code;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_err_reg
    if (!rst_ni) begin
      error_q <= NoError;
    end else begin
      error_q <= error_d;
    end
  end

  assign error_o = error_q;

  EscToFsmErr_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> error_o == FsmStateError);

endmodule : otp_part_check

`default_nettype wire

// ==== design/otp_part_store.sv ====
// Partition buffer registers, gated data and digest outputs, software access locks
`default_nettype none

`include "otp_part_defines.svh"

module otp_part_store (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Write port from the sequencer
  input  logic                                     buf_wr_en_i,
  input  logic [`OTP_CNT_W-1:0]                    blk_idx_i,
  input  logic [`OTP_BLOCK_W-1:0]                  otp_rdata_i,
  input  logic                                     unlocked_i,
  // Runtime locks from software
  input  logic                                     sw_read_lock_i,
  input  logic                                     sw_write_lock_i,
  // Buffered block at the current index, for the compare
  output logic [`OTP_BLOCK_W-1:0]                  buf_rd_data_o,
  output logic [`OTP_BLOCK_W*`OTP_PART_BLOCKS-1:0] data_o,
  output logic [`OTP_BLOCK_W-1:0]                  digest_o,
  output logic                                     read_lock_o,
  output logic                                     write_lock_o
);

  localparam int unsigned BlkW   = `OTP_BLOCK_W;
  localparam int unsigned Blocks = `OTP_PART_BLOCKS;

  logic [BlkW-1:0] blocks_q [Blocks];

  ////////////////////////////////////////////////////////////////////////////
  // Buffer registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_buf
    if (buf_wr_en_i) begin
      blocks_q[blk_idx_i] <= otp_rdata_i;
    end
  end

  assign buf_rd_data_o = blocks_q[blk_idx_i];

  // Hardware consumers see zeros until the partition is open
  always_comb begin : p_data_out
    for (int i = 0; i < Blocks; i++) begin
      data_o[i*BlkW +: BlkW] = unlocked_i ? blocks_q[i] : '0;
    end
  end

  // Digest is not gated
  assign digest_o = blocks_q[Blocks-1];

  ////////////////////////////////////////////////////////////////////////////
  // Access locks
  ////////////////////////////////////////////////////////////////////////////

  // A locked partition is closed to software in both directions
  assign read_lock_o  = sw_read_lock_i | ~unlocked_i;
  // Once a digest is in place the contents are frozen
  assign write_lock_o = sw_write_lock_i | ~unlocked_i | (digest_o != '0);

  LockedImpliesLocks_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !unlocked_i |-> read_lock_o && write_lock_o && data_o == '0);

endmodule : otp_part_store

`default_nettype wire

// ==== design/otp_part_buf.sv ====
// Buffered OTP partition top level: sequencing FSM, response check and buffer store
`default_nettype none

`include "otp_part_defines.svh"

module otp_part_buf
  import otp_macro_pkg::*;
  import otp_part_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Initialization
  input  logic                                     init_req_i,
  output logic                                     init_done_o,
  // Background consistency check
  input  logic                                     cnsty_chk_req_i,
  output logic                                     cnsty_chk_ack_o,
  // Life cycle and escalation
  input  logic                                     escalate_en_i,
  input  logic                                     check_byp_en_i,
  // Status
  output part_err_e                                error_o,
  output logic                                     fsm_err_o,
  // Software access locks
  input  logic                                     sw_read_lock_i,
  input  logic                                     sw_write_lock_i,
  output logic                                     read_lock_o,
  output logic                                     write_lock_o,
  // Buffered contents
  output logic [`OTP_BLOCK_W-1:0]                  digest_o,
  output logic [`OTP_BLOCK_W*`OTP_PART_BLOCKS-1:0] data_o,
  // OTP macro port
  output logic                                     otp_req_o,
  output logic [`OTP_ADDR_W-1:0]                   otp_addr_o,
  input  logic                                     otp_gnt_i,
  input  logic                                     otp_rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]                  otp_rdata_i,
  input  otp_macro_err_e                           otp_err_i
);

  read_phase_e              rsp_phase;
  rsp_verdict_e             rsp_verdict;
  logic                     buf_wr_en;
  logic [`OTP_CNT_W-1:0]    blk_idx;
  logic                     unlocked;
  logic [`OTP_BLOCK_W-1:0]  buf_rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  otp_part_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .init_req_i,
    .cnsty_chk_req_i,
    .escalate_en_i,
    .otp_gnt_i,
    .otp_rvalid_i,
    .otp_req_o,
    .otp_addr_o,
    .rsp_phase_o     ( rsp_phase   ),
    .rsp_verdict_i   ( rsp_verdict ),
    .buf_wr_en_o     ( buf_wr_en   ),
    .blk_idx_o       ( blk_idx     ),
    .unlocked_o      ( unlocked    ),
    .init_done_o,
    .cnsty_chk_ack_o,
    .fsm_err_o
  );

  // Response verdict and error register
  otp_part_check u_check (
    .clk_i,
    .rst_ni,
    .otp_rvalid_i,
    .otp_rdata_i,
    .otp_err_i,
    .rsp_phase_i     ( rsp_phase   ),
    .buf_rd_data_i   ( buf_rd_data ),
    .check_byp_en_i,
    .escalate_en_i,
    .rsp_verdict_o   ( rsp_verdict ),
    .error_o
  );

  ////////////////////////////////////////////////////////////////////////////
  // Buffer and locks
  ////////////////////////////////////////////////////////////////////////////

  otp_part_store u_store (
    .clk_i,
    .rst_ni,
    .buf_wr_en_i     ( buf_wr_en   ),
    .blk_idx_i       ( blk_idx     ),
    .otp_rdata_i,
    .unlocked_i      ( unlocked    ),
    .sw_read_lock_i,
    .sw_write_lock_i,
    .buf_rd_data_o   ( buf_rd_data ),
    .data_o,
    .digest_o,
    .read_lock_o,
    .write_lock_o
  );

endmodule : otp_part_buf

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// Testbench clock source and reset sequencer
`default_nettype none

module tb_clk_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 4 cycles, again on every restart request
  initial begin
    rst_no = 1'b0;
    forever begin
      repeat (4) @(negedge clk_o);
      rst_no = 1'b1;
      @(posedge restart_i);
      rst_no = 1'b0;
    end
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tests/otp_mem_model.sv ====
// Behavioral OTP macro with random grant delay and read latency and error injection
`default_nettype none

module otp_mem_model
  import otp_macro_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  // Macro port towards the partition
  input  logic           otp_req_i,
  input  logic [9:0]     otp_addr_i,
  output logic           otp_gnt_o,
  output logic           otp_rvalid_o,
  output logic [63:0]    otp_rdata_o,
  output otp_macro_err_e otp_err_o,
  // Backdoor write and error injection
  input  logic           wr_en_i,
  input  logic [9:0]     wr_addr_i,
  input  logic [63:0]    wr_data_i,
  input  logic           force_en_i,
  input  otp_macro_err_e force_err_i,
  output logic           addr_fail_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [63:0]    mem [1024];
  logic [15:0]    lfsr_q = 16'd29347;
  otp_macro_err_e force_err_q;
  int             force_cnt = 0;
  int             used_cnt = 0;
  int             gnt_wait;
  int             lat;
  logic           busy;
  logic [9:0]     addr_q;
  logic [9:0]     exp_addr;
  logic [1:0]     next_idx;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_q[15]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Backdoor side, sampled on the rising edge
  always @(posedge clk_i) begin : p_backdoor
    if (wr_en_i) begin
      mem[wr_addr_i] = wr_data_i;
    end
    if (force_en_i) begin
      force_err_q = force_err_i;
      force_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Port side, driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i or negedge rst_ni) begin : p_port
    if (!rst_ni) begin
      otp_gnt_o    = 1'b0;
      otp_rvalid_o = 1'b0;
      otp_rdata_o  = '0;
      otp_err_o    = MacroOk;
      addr_fail_o  = 1'b0;
      busy         = 1'b0;
      gnt_wait     = 0;
      next_idx     = '0;
    end else begin
      otp_rvalid_o = 1'b0;
      otp_err_o    = MacroOk;
      if (otp_gnt_o) begin
        // Grant was taken on the last rising edge
        otp_gnt_o = 1'b0;
      end else if (busy) begin
        if (lat == 0) begin
          otp_rvalid_o = 1'b1;
          otp_rdata_o  = mem[addr_q];
          if (force_cnt != used_cnt) begin
            otp_err_o = force_err_q;
            used_cnt  = force_cnt;
          end
          busy = 1'b0;
        end else begin
          lat--;
        end
      end else if (otp_req_i) begin
        if (gnt_wait == 0) begin
          otp_gnt_o = 1'b1;
          addr_q    = otp_addr_i;
          // Blocks are read in order from halfword 0x20, 4 halfwords apart
          exp_addr  = 10'h20 + {6'd0, next_idx, 2'b00};
          if (otp_addr_i != exp_addr) begin
            $display("CHECK FAILED otp_addr_o got 0x%0h expected 0x%0h", otp_addr_i, exp_addr);
            addr_fail_o = 1'b1;
          end
          next_idx = next_idx + 2'd1;
          busy     = 1'b1;
          draw_bits(2, lat);
          draw_bits(2, gnt_wait);
        end else begin
          gnt_wait--;
        end
      end
    end
  end

endmodule : otp_mem_model

`default_nettype wire

// ==== tests/tb_otp_part.sv ====
// Testbench top for the buffered OTP partition: DUT, OTP model, stimulus, assertions
`default_nettype none

`include "otp_part_defines.svh"

module tb_otp_part
  import otp_macro_pkg::*;
  import otp_part_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst_n, restart;
  logic init_req, cnsty_req, escalate, byp_en, sw_rl, sw_wl;
  logic init_done, cnsty_ack, fsm_err, read_lock, write_lock;
  logic [63:0] digest;
  logic [255:0] data;
  part_err_e error;
  logic otp_req, otp_gnt, otp_rvalid, wr_en, force_en, addr_fail;
  logic [9:0] otp_addr, wr_addr;
  logic [63:0] otp_rdata, wr_data;
  otp_macro_err_e otp_err, force_err;
  logic [63:0] exp_words [4];
  logic terminal_err;
  int cycle_cnt = 0;
  int ack_count = 0;
  int acks_before;

  tb_clk_gen u_clk (.restart_i(restart), .clk_o(clk), .rst_no(rst_n));

  otp_mem_model u_mem (
    .clk_i(clk), .rst_ni(rst_n), .otp_req_i(otp_req), .otp_addr_i(otp_addr),
    .otp_gnt_o(otp_gnt), .otp_rvalid_o(otp_rvalid), .otp_rdata_o(otp_rdata),
    .otp_err_o(otp_err), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .force_en_i(force_en), .force_err_i(force_err), .addr_fail_o(addr_fail)
  );

  otp_part_buf dut0 (
    .clk_i(clk), .rst_ni(rst_n), .init_req_i(init_req), .init_done_o(init_done),
    .cnsty_chk_req_i(cnsty_req), .cnsty_chk_ack_o(cnsty_ack), .escalate_en_i(escalate),
    .check_byp_en_i(byp_en), .error_o(error), .fsm_err_o(fsm_err),
    .sw_read_lock_i(sw_rl), .sw_write_lock_i(sw_wl), .read_lock_o(read_lock),
    .write_lock_o(write_lock), .digest_o(digest), .data_o(data),
    .otp_req_o(otp_req), .otp_addr_o(otp_addr), .otp_gnt_i(otp_gnt),
    .otp_rvalid_i(otp_rvalid), .otp_rdata_i(otp_rdata), .otp_err_i(otp_err)
  );

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      report_fail("Value mismatch");
    end
  endtask

  // Pattern depends on every address bit
  function automatic logic [63:0] word_pattern(input logic [9:0] a);
    return {6'h2b, a, 6'h15, ~a, 16'hc3a5 ^ {6'd0, a}, 16'h5a3c + {6'd0, a}};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Assertions and run limit
  ////////////////////////////////////////////////////////////////////////////

  assign terminal_err = !(error inside {NoError, MacroEccCorrError});

  EscToErr_A: assert property (@(posedge clk) disable iff (!rst_n)
    escalate |=> error == FsmStateError)
    else begin
      $display("CHECK FAILED error_o got 0x%0h expected 0x%0h", error, FsmStateError);
      report_fail("Escalation not reported");
    end

  // Terminal error closes the partition
  ErrLocked_A: assert property (@(posedge clk) disable iff (!rst_n)
    terminal_err |-> !init_done && data == '0 && read_lock && write_lock)
    else begin
      $display("CHECK FAILED init_done_o 0x%0h locks 0x%0h%0h", init_done, read_lock, write_lock);
      report_fail("Partition open after a terminal error");
    end

  ErrAck_A: assert property (@(posedge clk) disable iff (!rst_n)
    terminal_err && cnsty_req |-> cnsty_ack)
    else begin
      $display("CHECK FAILED cnsty_chk_ack_o got 0x%0h expected 0x1", cnsty_ack);
      report_fail("Check request not acknowledged in the error state");
    end

  // FSM error flag follows escalation
  FsmErr_A: assert property (@(posedge clk) disable iff (!rst_n)
    fsm_err == escalate)
    else begin
      $display("CHECK FAILED fsm_err_o got 0x%0h expected 0x%0h", fsm_err, escalate);
      report_fail("FSM error flag does not match escalation");
    end

  always @(posedge clk) begin
    cycle_cnt++;
    if (rst_n && cnsty_ack) ack_count++;
    if (addr_fail) begin
      report_fail("OTP request seen at an unexpected address");
    end else if (cycle_cnt >= 2000) begin
      report_fail("Timeout, the run did not finish in 2000 cycles");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic restart_dut();
    {init_req, cnsty_req, escalate, byp_en} = '0;
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    while (!rst_n) @(negedge clk);
  endtask

  task automatic write_word(input logic [1:0] idx, input logic [63:0] w);
    wr_addr = 10'h20 + {6'd0, idx, 2'b00};
    wr_data = w;
    wr_en   = 1'b1;
    @(negedge clk);
    wr_en   = 1'b0;
  endtask

  task automatic load_all(input logic zero_digest);
    for (int i = 0; i < 4; i++) begin
      exp_words[i] = (zero_digest && i == 3) ? '0 : word_pattern(10'h20 + 10'(i * 4));
      write_word(2'(i), exp_words[i]);
    end
  endtask

  task automatic force_next(input otp_macro_err_e code);
    force_err = code;
    force_en  = 1'b1;
    @(negedge clk);
    force_en  = 1'b0;
  endtask

  task automatic run_init();
    init_req = 1'b1;
    @(negedge clk);
    init_req = 1'b0;
    while (!init_done) @(negedge clk);
  endtask

  // One request, exactly one acknowledge
  task automatic run_check();
    acks_before = ack_count;
    cnsty_req = 1'b1;
    @(negedge clk);
    cnsty_req = 1'b0;
    while (ack_count == acks_before) @(negedge clk);
    repeat (8) @(negedge clk);
    check_eq("cnsty_chk_ack_o pulses", 256'(ack_count - acks_before), 256'(1));
  endtask

  task automatic check_open();
    check_eq("init_done_o", 256'(init_done), 256'(1));
    check_eq("data_o", data, {exp_words[3], exp_words[2], exp_words[1], exp_words[0]});
    check_eq("digest_o", 256'(digest), 256'(exp_words[3]));
    check_eq("read_lock_o", 256'(read_lock), 256'(sw_rl));
    check_eq("write_lock_o", 256'(write_lock), 256'(sw_wl | (exp_words[3] != '0)));
  endtask

  task automatic check_closed();
    check_eq("init_done_o", 256'(init_done), 256'(0));
    check_eq("data_o", data, 256'(0));
    check_eq("read_lock_o", 256'(read_lock), 256'(1));
    check_eq("write_lock_o", 256'(write_lock), 256'(1));
  endtask

  initial begin
    {restart, init_req, cnsty_req, escalate, byp_en, sw_rl, sw_wl} = '0;
    {wr_en, force_en} = '0;
    wr_addr   = '0;
    wr_data   = '0;
    force_err = MacroOk;
    while (rst_n !== 1'b1) @(negedge clk);
    load_all(1'b0);
    // Reset values
    check_eq("otp_req_o", 256'(otp_req), 256'(0));
    check_eq("cnsty_chk_ack_o", 256'(cnsty_ack), 256'(0));
    check_closed();
    check_eq("error_o", 256'(error), 256'(NoError));
    // Initialization, clean check, then a corrected ECC response
    run_init();
    check_open();
    run_check();
    check_eq("error_o", 256'(error), 256'(NoError));
    force_next(MacroEccCorr);
    run_check();
    check_eq("error_o", 256'(error), 256'(MacroEccCorrError));
    check_eq("init_done_o", 256'(init_done), 256'(1));
    // Zero digest leaves write lock to software
    restart_dut();
    load_all(1'b1);
    sw_rl = 1'b1;
    run_init();
    check_open();
    sw_wl = 1'b1;
    @(negedge clk);
    check_open();
    {sw_rl, sw_wl} = '0;
    // Mismatch on the digest block
    restart_dut();
    load_all(1'b0);
    run_init();
    write_word(2'd3, ~exp_words[3]);
    run_check();
    check_eq("error_o", 256'(error), 256'(CheckFailError));
    check_closed();
    // Digest stays visible while the partition is locked
    check_eq("digest_o", 256'(digest), 256'(exp_words[3]));
    // Same mismatch with the compare bypassed
    restart_dut();
    load_all(1'b0);
    run_init();
    write_word(2'd1, ~exp_words[1]);
    byp_en = 1'b1;
    run_check();
    byp_en = 1'b0;
    check_eq("error_o", 256'(error), 256'(NoError));
    // Macro error during initialization, then escalation
    restart_dut();
    load_all(1'b0);
    force_next(otp_macro_pkg::MacroError);
    init_req = 1'b1;
    @(negedge clk);
    init_req = 1'b0;
    while (error == NoError) @(negedge clk);
    check_eq("error_o", 256'(error), 256'(otp_part_pkg::MacroError));
    repeat (10) @(negedge clk);
    check_closed();
    escalate = 1'b1;
    @(negedge clk);
    escalate = 1'b0;
    check_eq("error_o", 256'(error), 256'(FsmStateError));
    acks_before = ack_count;
    cnsty_req = 1'b1;
    #1;
    check_eq("cnsty_chk_ack_o", 256'(cnsty_ack), 256'(1));
    @(negedge clk);
    cnsty_req = 1'b0;
    check_eq("cnsty_chk_ack_o pulses", 256'(ack_count - acks_before), 256'(1));
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_otp_part

`default_nettype wire

// ==== src.f ====
+incdir+design
design/otp_macro_pkg.sv
design/otp_part_pkg.sv
design/otp_part_fsm.sv
design/otp_part_check.sv
design/otp_part_store.sv
design/otp_part_buf.sv
tests/tb_clk_gen.sv
tests/otp_mem_model.sv
tests/tb_otp_part.sv

// ==== Makefile ====
# Verilator flow for the buffered OTP partition

TB_TOP = tb_otp_part

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module otp_part_buf

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
